//--- hdl/ahb_sram_settings.svh
`ifndef AHB_SRAM_SETTINGS_SVH
`define AHB_SRAM_SETTINGS_SVH

////////////////////
// Bus widths
////////////////////

// Byte address over both banks
// Bit 10 picks the bank and bits 9 to 0 address 1 KB inside it
`define AHB_ADDR_W 11

// Data bus width in bits
`define AHB_DATA_W 32

////////////////////
// Memory
////////////////////

// Words per bank
// 256 words of 4 bytes fill one 1 KB bank
`define BANK_DEPTH 256

`endif

//--- hdl/ahb_sram_pkg.sv
`default_nettype none

`include "ahb_sram_settings.svh"

package ahb_sram_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  // Byte address as seen on HADDR
  typedef logic [`AHB_ADDR_W-1:0] ahb_addr_t;
  // One data word on HWDATA or HRDATA
  typedef logic [`AHB_DATA_W-1:0] ahb_data_t;
  // One enable per byte lane
  typedef logic [`AHB_DATA_W/8-1:0] ahb_be_t;
  typedef logic [1:0] htrans_t;
  typedef logic [2:0] hsize_t;

  ////////////////////
  // Transfer codes
  ////////////////////

  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // Sizes up to the bus width only
  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY = 1'b0;

  ////////////////////
  // Bus bundles
  ////////////////////

  // Address phase from the master
  typedef struct packed {
    ahb_addr_t haddr;
    htrans_t   htrans;
    logic      hwrite;
    hsize_t    hsize;
  } ahb_req_t;

  // Response of one slave, or of the whole subsystem after the mux
  typedef struct packed {
    ahb_data_t hrdata;
    logic      hreadyout;
    logic      hresp;
  } ahb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/ram_1r1w.sv
`default_nettype none

module ram_1r1w #(
  parameter int ABITS = 8,
  parameter int DBITS = 32
) (
  input  wire logic               HCLK,
  input  wire logic               HRESETn,
  input  wire logic [ABITS-1:0]   waddr,
  input  wire logic               we,
  input  wire logic [DBITS/8-1:0] be,
  input  wire logic [DBITS-1:0]   din,
  input  wire logic [ABITS-1:0]   raddr,
  output logic      [DBITS-1:0]   dout
);

  localparam int LANES = DBITS / 8;

  logic [DBITS-1:0] mem [2**ABITS];
  // Array word taken at the read edge
  logic [DBITS-1:0] rd_q;
  // Written word kept for the bypass
  logic [DBITS-1:0] fwd_data_q;
  logic             fwd_q;

  // Write port
  // Each lane lands only when its enable is set
  always_ff @(posedge HCLK) begin
    for (int i = 0; i < LANES; i++) begin
      if (we && be[i]) begin
        mem[waddr][i*8 +: 8] <= din[i*8 +: 8];
      end
    end
  end

  // Read port samples raddr on every edge
  // On a collision the array still returns the old word here
  always_ff @(posedge HCLK) begin
    rd_q <= mem[raddr];
  end

  // Bypass only for full words
  // Partial collisions are left to the slave, which waits a cycle
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fwd_q <= 1'b0;
    end else begin
      fwd_q <= we && (&be) && (waddr == raddr);
    end
  end

  always_ff @(posedge HCLK) begin
    if (we) begin
      fwd_data_q <= din;
    end
  end

  assign dout = fwd_q ? fwd_data_q : rd_q;

endmodule

`default_nettype wire

//--- hdl/ahb_sram_slave.sv
`default_nettype none

module ahb_sram_slave #(
  parameter int MEM_DEPTH         = 256,
  parameter bit REGISTERED_OUTPUT = 1'b0
) (
  input  wire logic                    HCLK,
  input  wire logic                    HRESETn,
  input  wire logic                    sel,
  input  wire ahb_sram_pkg::ahb_req_t  req,
  input  wire ahb_sram_pkg::ahb_data_t wdata,
  input  wire logic                    hready,
  output ahb_sram_pkg::ahb_rsp_t       rsp
);

  import ahb_sram_pkg::*;

  // Low address bits that pick a byte lane
  localparam int LANE_BITS = $clog2($bits(ahb_be_t));
  localparam int MEM_ABITS = $clog2(MEM_DEPTH);

  // Word index inside this bank
  typedef logic [MEM_ABITS-1:0] word_addr_t;

  logic       active;
  logic       accept;
  word_addr_t req_word;
  // Pending write of the previous address phase
  logic       we_q;
  ahb_be_t    be_q;
  // Address of the last accepted phase, write or read
  word_addr_t addr_q;
  word_addr_t raddr;
  logic       contention;
  logic       stall;
  logic       hreadyout_q;
  ahb_data_t  ram_dout;

  ////////////////////
  // Lane decode
  ////////////////////

  // Lanes touched by a transfer of this size at this address
  function automatic ahb_be_t lane_enables(input hsize_t hsize, input ahb_addr_t haddr);
    ahb_be_t base;
    case (hsize)
      HSIZE_WORD:  base = '1;
      HSIZE_HWORD: base = ahb_be_t'(3);
      default:     base = ahb_be_t'(1);
    endcase
    return base << haddr[LANE_BITS-1:0];
  endfunction

  // IDLE and BUSY carry no transfer
  assign active   = (req.htrans != HTRANS_IDLE) && (req.htrans != HTRANS_BUSY);
  assign accept   = sel && hready && active;
  assign req_word = req.haddr[LANE_BITS +: MEM_ABITS];

  ////////////////////
  // Address phase
  ////////////////////

  // Write strobe for the data phase
  // The RAM write trails the address phase by one edge
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else if (hready) begin
      we_q <= sel && active && req.hwrite;
    end
  end

  // Lanes and word address held through the data phase
  always_ff @(posedge HCLK) begin
    if (hready) begin
      be_q   <= lane_enables(req.hsize, req.haddr);
      addr_q <= req_word;
    end
  end

  // Read of the word that is being written on this very edge
  assign contention = we_q && accept && !req.hwrite && (addr_q == req_word);
  // The RAM resolves full words itself
  assign stall      = contention && !(&be_q);

  ////////////////////
  // Memory
  ////////////////////

  ram_1r1w #(
    .ABITS (MEM_ABITS),
    .DBITS ($bits(ahb_data_t))
  ) ram_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (addr_q),
    .we      (we_q),
    .be      (be_q),
    .din     (wdata),
    .raddr   (raddr),
    .dout    (ram_dout)
  );

  ////////////////////
  // Read path
  ////////////////////

  generate
    if (!REGISTERED_OUTPUT) begin : g_comb_read
      // Address phase goes straight to the RAM
      // During a stall the held word is read again and now holds the merged bytes
      assign raddr = hready ? req_word : addr_q;

      always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
          hreadyout_q <= 1'b1;
        end else begin
          hreadyout_q <= !stall;
        end
      end
    end else begin : g_reg_read
      // RAM reads the held address one edge after the address phase
      // so any write to that word has already landed
      assign raddr = addr_q;

      // One wait state after every accepted read
      always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
          hreadyout_q <= 1'b1;
        end else begin
          hreadyout_q <= !(accept && !req.hwrite);
        end
      end
    end
  endgenerate

  // Both banks span the map so the answer is always OKAY
  always_comb begin
    rsp.hrdata    = ram_dout;
    rsp.hreadyout = hreadyout_q;
    rsp.hresp     = HRESP_OKAY;
  end

endmodule

`default_nettype wire

//--- hdl/ahb_bank_mux.sv
`default_nettype none

`include "ahb_sram_settings.svh"

module ahb_bank_mux (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire ahb_sram_pkg::ahb_req_t req,
  input  wire ahb_sram_pkg::ahb_rsp_t rsp_bank0,
  input  wire ahb_sram_pkg::ahb_rsp_t rsp_bank1,
  output logic [1:0]                  sel,
  output ahb_sram_pkg::ahb_rsp_t      rsp
);

  import ahb_sram_pkg::*;

  // Top address bit splits the map into two banks
  localparam int BANK_BIT = `AHB_ADDR_W - 1;

  // Bank of the current address phase
  logic bank;
  // Bank that owns the current data phase
  logic bank_q;
  logic active;

  ////////////////////
  // Address decode
  ////////////////////

  assign bank = req.haddr[BANK_BIT];

  // One select line per bank
  // Slaves qualify it with HTRANS themselves
  assign sel  = {bank, !bank};

  assign active = (req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ);

  ////////////////////
  // Data phase select
  ////////////////////

  // Follows each accepted transfer
  // Idle cycles leave the last owner in place
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      bank_q <= 1'b0;
    end else if (rsp.hreadyout && active) begin
      bank_q <= bank;
    end
  end

  // The chosen hreadyout is also the bus HREADY
  always_comb begin
    if (bank_q) begin
      rsp = rsp_bank1;
    end else begin
      rsp = rsp_bank0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ahb_sram_top.sv
`default_nettype none

`include "ahb_sram_settings.svh"

module ahb_sram_top (
  input  wire logic                    HCLK,
  input  wire logic                    HRESETn,
  input  wire ahb_sram_pkg::ahb_req_t  req,
  input  wire ahb_sram_pkg::ahb_data_t wdata,
  output ahb_sram_pkg::ahb_rsp_t       rsp
);

  import ahb_sram_pkg::*;

  // One hot bank select from the decoder
  logic [1:0] sel;
  ahb_rsp_t   rsp_bank0;
  ahb_rsp_t   rsp_bank1;

  ////////////////////
  // Decoder and mux
  ////////////////////

  ahb_bank_mux mux_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .req       (req),
    .rsp_bank0 (rsp_bank0),
    .rsp_bank1 (rsp_bank1),
    .sel       (sel),
    .rsp       (rsp)
  );

  ////////////////////
  // Banks
  ////////////////////

  // Bank 0 answers reads without wait states
  ahb_sram_slave #(
    .MEM_DEPTH         (`BANK_DEPTH),
    .REGISTERED_OUTPUT (1'b0)
  ) bank0_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .sel     (sel[0]),
    .req     (req),
    .wdata   (wdata),
    .hready  (rsp.hreadyout),
    .rsp     (rsp_bank0)
  );

  // Bank 1 adds one wait state on every read
  ahb_sram_slave #(
    .MEM_DEPTH         (`BANK_DEPTH),
    .REGISTERED_OUTPUT (1'b1)
  ) bank1_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .sel     (sel[1]),
    .req     (req),
    .wdata   (wdata),
    .hready  (rsp.hreadyout),
    .rsp     (rsp_bank1)
  );

endmodule

`default_nettype wire

//--- test/ahb_sram_checker.sv
`default_nettype none

module ahb_sram_checker (
  input  wire logic                    HCLK,
  input  wire logic                    HRESETn,
  input  wire ahb_sram_pkg::ahb_req_t  req,
  input  wire ahb_sram_pkg::ahb_data_t wdata,
  input  wire ahb_sram_pkg::ahb_rsp_t  rsp,
  output int                           data_errors,
  output int                           wait_errors,
  output int                           bus_errors,
  output int                           reads_checked
);

  timeunit 1ns;
  timeprecision 1ps;

  import ahb_sram_pkg::*;

  // Top address bit picks the bank
  localparam int BANK_BIT = $bits(ahb_addr_t) - 1;

  // Byte model of both banks
  logic [7:0] model [2**$bits(ahb_addr_t)];

  // Transfer whose data phase is open
  logic     dp_valid = 1'b0;
  ahb_req_t dp_req;
  string    dp_name;
  int       dp_waits;
  int       dp_waits_exp;
  // Write whose data phase ends on the current edge
  logic     prev_write;
  ahb_req_t prev_req;
  // Set during reset until the first edge after release
  logic     after_reset = 1'b0;

  int n_data  = 0;
  int n_wait  = 0;
  int n_bus   = 0;
  int n_reads = 0;

  assign data_errors   = n_data;
  assign wait_errors   = n_wait;
  assign bus_errors    = n_bus;
  assign reads_checked = n_reads;

  ////////////////////
  // Model
  ////////////////////

  // Bytes of the transfer land in their own lanes only
  task automatic write_model(input ahb_req_t r, input ahb_data_t data);
    ahb_addr_t idx;
    for (int b = 0; b < (1 << r.hsize); b++) begin
      idx = r.haddr + ahb_addr_t'(b);
      model[idx] = data[idx[1:0]*8 +: 8];
    end
  endtask

  // Lanes outside the transfer are masked off
  task automatic check_read(input ahb_req_t r, input ahb_data_t got, input string name);
    ahb_addr_t idx;
    ahb_data_t exp_word;
    ahb_data_t mask;
    exp_word = '0;
    mask     = '0;
    for (int b = 0; b < (1 << r.hsize); b++) begin
      idx = r.haddr + ahb_addr_t'(b);
      exp_word[idx[1:0]*8 +: 8] = model[idx];
      mask[idx[1:0]*8 +: 8]     = 8'hff;
    end
    n_reads++;
    if ((got & mask) !== exp_word) begin
      $display("FAILED %s at %h: expected %h, actual %h", name, r.haddr, exp_word, got & mask);
      n_data++;
    end
  endtask

  ////////////////////
  // Data phases
  ////////////////////

  // Expected wait states of the transfer accepted on this edge
  task automatic open_data_phase();
    dp_valid = (req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ);
    dp_req   = req;
    dp_waits = 0;
    if (req.hwrite) begin
      dp_name      = "write";
      dp_waits_exp = 0;
    end else if (req.haddr[BANK_BIT]) begin
      dp_name      = "bank1_read";
      dp_waits_exp = 1;
    end else if (prev_write && (prev_req.haddr[BANK_BIT:2] == req.haddr[BANK_BIT:2])) begin
      // Full words are forwarded and partial ones cost a cycle
      if (prev_req.hsize == HSIZE_WORD) begin
        dp_name      = "bank0_read_after_word_write";
        dp_waits_exp = 0;
      end else begin
        dp_name      = "bank0_read_after_partial_write";
        dp_waits_exp = 1;
      end
    end else begin
      dp_name      = "bank0_read";
      dp_waits_exp = 0;
    end
  endtask

  task automatic close_data_phase();
    if (dp_waits != dp_waits_exp) begin
      $display("FAILED %s wait states at %h: expected %0d, actual %0d",
               dp_name, dp_req.haddr, dp_waits_exp, dp_waits);
      n_wait++;
    end
    if (dp_req.hwrite) begin
      write_model(dp_req, wdata);
    end else begin
      check_read(dp_req, rsp.hrdata, dp_name);
    end
  endtask

  // Bus values are taken before the edge updates the DUT
  always @(posedge HCLK) begin
    if (!HRESETn) begin
      dp_valid    = 1'b0;
      after_reset = 1'b1;
    end else begin
      // Reset values of the response on the first edge after release
      if (after_reset) begin
        after_reset = 1'b0;
        if ((rsp.hreadyout !== 1'b1) || (rsp.hresp !== HRESP_OKAY)) begin
          $display("Error: the bus is not ready with an OKAY response after reset");
          n_bus++;
        end
      end
      if (rsp.hresp !== HRESP_OKAY) begin
        $display("Error: the response is not OKAY near address %h", dp_req.haddr);
        n_bus++;
      end
      if (rsp.hreadyout === 1'b1) begin
        prev_write = dp_valid && dp_req.hwrite;
        prev_req   = dp_req;
        if (dp_valid) begin
          close_data_phase();
        end
        open_data_phase();
      end else if (dp_valid) begin
        dp_waits++;
      end else begin
        $display("Error: the bus inserted a wait state with no transfer in progress");
        n_bus++;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/ahb_sram_tb.sv
`default_nettype none

module ahb_sram_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ahb_sram_pkg::*;

  // One word write for every word of both banks
  localparam int FILL_WORDS       = (2 ** $bits(ahb_addr_t)) / 4;
  localparam int RANDOM_TRANSFERS = 2000;
  // Three cycles per transfer covers fill, read back and random traffic
  localparam int CYCLE_LIMIT      = (FILL_WORDS + RANDOM_TRANSFERS) * 3 + 100;

  logic        HCLK;
  logic        HRESETn;
  ahb_req_t    req;
  ahb_data_t   wdata;
  ahb_rsp_t    rsp;
  // Write data for the transfer now in its data phase
  ahb_data_t   next_wdata;
  logic [15:0] lfsr_state;
  int          cycles = 0;
  int          data_errors;
  int          wait_errors;
  int          bus_errors;
  int          reads_checked;

  ////////////////////
  // Random numbers
  ////////////////////

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  ////////////////////
  // Clock, DUT, checker
  ////////////////////

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  ahb_sram_top dut_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req),
    .wdata   (wdata),
    .rsp     (rsp)
  );

  ahb_sram_checker checker_i (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .req           (req),
    .wdata         (wdata),
    .rsp           (rsp),
    .data_errors   (data_errors),
    .wait_errors   (wait_errors),
    .bus_errors    (bus_errors),
    .reads_checked (reads_checked)
  );

  always @(posedge HCLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the bus stopped accepting transfers", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Address phase held until HREADY takes it
  // HREADY only moves on rising edges so the falling edge sees a settled value
  task automatic send(input ahb_req_t next_req, input ahb_data_t data);
    @(negedge HCLK);
    req   = next_req;
    wdata = next_wdata;
    while (rsp.hreadyout !== 1'b1) begin
      @(negedge HCLK);
    end
    next_wdata = data;
  endtask

  initial begin
    ahb_req_t   r;
    logic [8:0] word;
    logic [1:0] offset;
    logic [1:0] size_bits;
    HRESETn    = 1'b0;
    req        = '0;
    wdata      = '0;
    next_wdata = '0;
    lfsr_state = 16'd16;
    word       = '0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    // Fill then read back every word
    for (int pass = 0; pass < 2; pass++) begin
      for (int w = 0; w < FILL_WORDS; w++) begin
        r.htrans = HTRANS_NONSEQ;
        r.hwrite = (pass == 0);
        r.hsize  = HSIZE_WORD;
        r.haddr  = ahb_addr_t'(w * 4);
        send(r, random_bits(32));
      end
    end

    // Random mix, a quarter of them reuse the last word
    for (int t = 0; t < RANDOM_TRANSFERS; t++) begin
      r.htrans  = (random_bits(2) == 0) ? HTRANS_IDLE : HTRANS_NONSEQ;
      r.hwrite  = 1'(random_bits(1));
      size_bits = 2'(random_bits(2));
      r.hsize   = (size_bits == 2'd3) ? HSIZE_WORD : hsize_t'(size_bits);
      if (random_bits(2) != 0) begin
        word = 9'(random_bits(9));
      end
      offset = 2'(random_bits(2));
      if (r.hsize == HSIZE_WORD) begin
        offset = 2'd0;
      end else if (r.hsize == HSIZE_HWORD) begin
        offset[0] = 1'b0;
      end
      r.haddr = ahb_addr_t'({word, offset});
      send(r, random_bits(32));
    end

    // Idle phase drains the last data phase
    r        = '0;
    r.htrans = HTRANS_IDLE;
    send(r, '0);
    repeat (3) @(negedge HCLK);

    $display("Summary: %0d reads checked, %0d data errors, %0d wait-state errors, %0d bus errors",
             reads_checked, data_errors, wait_errors, bus_errors);
    if ((data_errors + wait_errors + bus_errors) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/ahb_sram_pkg.sv
hdl/ram_1r1w.sv
hdl/ahb_sram_slave.sv
hdl/ahb_bank_mux.sv
hdl/ahb_sram_top.sv
test/ahb_sram_checker.sv
test/ahb_sram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module ahb_sram_tb -Mdir obj_dir -o ahb_sram_sim \
  && ./obj_dir/ahb_sram_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
